/* sim.f */
design/snoop_pkg.sv
design/snoop_cfg_regs.sv
design/trace_capture.sv
design/trace_buffer.sv
design/event_cdc_src.sv
design/snoop_top.sv
testbench/snoop_top_asserts.sv
testbench/tb_snoop_top.sv

/* Bender.yml */
package:
  name: snoop_frontend

sources:
  - files:
      - design/snoop_pkg.sv
      - design/snoop_cfg_regs.sv
      - design/trace_capture.sv
      - design/trace_buffer.sv
      - design/event_cdc_src.sv
      - design/snoop_top.sv
  - target: test
    files:
      - testbench/snoop_top_asserts.sv
      - testbench/tb_snoop_top.sv

/* testbench/tb_snoop_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_snoop_top;

  import snoop_pkg::*;

  localparam int unsigned NumCores  = NumCoresDef;
  localparam int unsigned EvDepth   = 2 ** EventLogDepthDef;
  localparam int unsigned TrDepth   = 2 ** TraceLogDepthDef;
  localparam int unsigned ClkPeriod = 8;
  // Cycle estimates per phase for reset, format, trigger, watermark and events
  localparam int unsigned TestCycles = 10 + 180 + 100 + 40 + 90;
  localparam int unsigned WatchdogNs = (TestCycles * 2 + 200) * ClkPeriod;

  logic                                     clk;
  logic                                     arst_n;
  logic                                     cfg_we;
  reg_idx_t                                 cfg_idx;
  word_t                                    cfg_wdata;
  branch_trace_t [NumCores-1:0]             trace;
  logic                                     rd_pop;
  trace_rec_t                               rd_rec;
  logic [TraceLogDepthDef:0]                rd_count;
  logic                                     wm_irq;
  logic                                     trig_irq;
  pmu_event_t [NumCores-1:0]                ev;
  logic [NumCores-1:0][EventLogDepthDef:0]  ev_wptr;
  pmu_event_t [NumCores-1:0][EvDepth-1:0]   ev_data;
  logic [NumCores-1:0][EventLogDepthDef:0]  ev_rptr;

  // Reference model state read by the bound checker
  integer                                   seed;
  trace_rec_t                               exp_q[$];
  trace_rec_t                               exp_head;
  logic                                     count_chk;
  int unsigned                              exp_count;
  logic                                     rec_acc;
  logic                                     rec_acc_d;
  int unsigned                              exp_fill;
  int unsigned                              wm_shadow;
  int unsigned                              sel_shadow;
  logic                                     trace_en_shadow;
  logic                                     trig_en_shadow;
  word_t                                    trig_shadow;
  logic                                     exp_trig;
  logic [NumCores-1:0][EventLogDepthDef:0]  exp_wptr;
  pmu_event_t                               exp_ev [NumCores];
  int unsigned                              ev_slot [NumCores];
  logic [NumCores-1:0]                      ev_chk;
  int unsigned                              ev_wr [NumCores];
  int unsigned                              ev_rd [NumCores];
  pmu_event_t                               ev_q [NumCores][$];

  snoop_top dut0 (
    .clk_i           ( clk       ),
    .arst_n_i        ( arst_n    ),
    .cfg_we_i        ( cfg_we    ),
    .cfg_idx_i       ( cfg_idx   ),
    .cfg_wdata_i     ( cfg_wdata ),
    .trace_i         ( trace     ),
    .rd_pop_i        ( rd_pop    ),
    .rd_rec_o        ( rd_rec    ),
    .rd_count_o      ( rd_count  ),
    .watermark_irq_o ( wm_irq    ),
    .trigger_irq_o   ( trig_irq  ),
    .ev_i            ( ev        ),
    .ev_wptr_o       ( ev_wptr   ),
    .ev_data_o       ( ev_data   ),
    .ev_rptr_i       ( ev_rptr   )
  );

  bind snoop_top snoop_top_asserts #(
    .NumCores      ( NumCores      ),
    .TraceLogDepth ( TraceLogDepth ),
    .EventLogDepth ( EventLogDepth )
  ) i_asserts (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .rd_pop_i        ( rd_pop_i        ),
    .rd_rec_o        ( rd_rec_o        ),
    .rd_count_o      ( rd_count_o      ),
    .watermark_irq_o ( watermark_irq_o ),
    .trigger_irq_o   ( trigger_irq_o   ),
    .ev_wptr_o       ( ev_wptr_o       ),
    .ev_data_o       ( ev_data_o       )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Expected fill level, one stage of capture ahead of the push
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rec_acc_d <= 1'b0;
      exp_fill  <= 0;
    end else begin
      rec_acc_d <= rec_acc;
      if (rec_acc_d) begin
        exp_fill <= exp_fill + 1;
      end else if (rd_pop) begin
        exp_fill <= exp_fill - 1;
      end
    end
  end

  // ------------------------------------------------------------
  // Reference rules
  // ------------------------------------------------------------
  function automatic trace_rec_t format_trace(branch_trace_t t);
    trace_rec_t r;
    r.priv     = t.priv;
    r.pc_src_h = {1'b0, t.src_pc[62:32]};
    r.pc_src_l = {t.src_pc[31:1], 1'b0};
    r.pc_dst_h = {1'b0, t.dst_pc[62:32]};
    r.pc_dst_l = {t.dst_pc[31:1], 1'b0};
    r.metadata = word_t'(t.ctr_type);
    r.opcode   = t.instr;
    return r;
  endfunction

  function automatic logic [EventLogDepthDef:0] to_gray(int unsigned n);
    logic [EventLogDepthDef:0] b;
    b = n[EventLogDepthDef:0];
    return b ^ (b >> 1);
  endfunction

  // ------------------------------------------------------------
  // Stimulus tasks, all start and end on a falling edge
  // ------------------------------------------------------------
  task automatic write_cfg(input reg_idx_t idx, input word_t data);
    cfg_we    = 1'b1;
    cfg_idx   = idx;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
    case (idx)
      RegCoreSel:   sel_shadow = data[CoreIdxWidth-1:0];
      RegWatermark: wm_shadow = data[CountWidth-1:0];
      RegTrigAddr:  trig_shadow = data;
      default: begin
        trace_en_shadow = data[0];
        trig_en_shadow  = data[1];
      end
    endcase
  endtask

  task automatic drive_traces(input int unsigned n, input logic hit, input logic all_valid);
    trace_rec_t rec;
    word_t      r;
    for (int i = 0; i < n; i++) begin
      for (int c = 0; c < NumCores; c++) begin
        r = $random(seed);
        trace[c].valid    = all_valid | (r[7:6] != 2'b00);
        trace[c].src_pc   = {$random(seed), $random(seed)};
        trace[c].dst_pc   = {$random(seed), $random(seed)};
        trace[c].ctr_type = r[3:0];
        trace[c].priv     = r[5:4];
        trace[c].instr    = $random(seed);
        // Some sources hit the trigger address with bit 0 left random
        if (hit && r[9:8] == 2'b00) begin
          trace[c].src_pc[31:1] = trig_shadow[31:1];
        end
      end
      exp_trig = 1'b0;
      rec_acc  = 1'b0;
      if (sel_shadow < NumCores && trace[sel_shadow].valid && trace_en_shadow) begin
        rec = format_trace(trace[sel_shadow]);
        if (exp_q.size() < TrDepth) begin
          exp_q.push_back(rec);
          rec_acc = 1'b1;
        end
        exp_trig = trig_en_shadow && (rec.pc_src_l == trig_shadow);
      end
      @(negedge clk);
    end
    trace    = '0;
    exp_trig = 1'b0;
    rec_acc  = 1'b0;
  endtask

  task automatic drain_records();
    // Two-cycle path from trace input to the buffer
    repeat (2) @(negedge clk);
    count_chk = 1'b1;
    exp_count = exp_q.size();
    @(negedge clk);
    count_chk = 1'b0;
    while (exp_q.size() != 0) begin
      rd_pop   = 1'b1;
      exp_head = exp_q.pop_front();
      @(negedge clk);
    end
    rd_pop    = 1'b0;
    count_chk = 1'b1;
    exp_count = 0;
    @(negedge clk);
    count_chk = 1'b0;
  endtask

  task automatic event_round(input int unsigned n);
    word_t r;
    for (int i = 0; i < n; i++) begin
      for (int c = 0; c < NumCores; c++) begin
        r     = $random(seed);
        ev[c] = pmu_event_t'(r);
        if (r[31:30] == 2'b00) begin
          ev[c].e_id = '0;
        end
        // With the reader stalled a full FIFO holds four events
        if (ev[c].e_id != '0 && ev_wr[c] - ev_rd[c] < EvDepth) begin
          ev_q[c].push_back(ev[c]);
          ev_wr[c]++;
          exp_wptr[c] = to_gray(ev_wr[c]);
        end
      end
      @(negedge clk);
    end
    ev = '0;
    @(negedge clk);
    for (int c = 0; c < NumCores; c++) begin
      while (ev_q[c].size() != 0) begin
        ev_chk[c]  = 1'b1;
        ev_slot[c] = ev_rd[c] % EvDepth;
        exp_ev[c]  = ev_q[c].pop_front();
        ev_rd[c]++;
        ev_rptr[c] = to_gray(ev_rd[c]);
        @(negedge clk);
      end
      ev_chk[c] = 1'b0;
    end
    // Read pointer crosses the synchronizer
    repeat (SyncStagesDef + 1) @(negedge clk);
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    seed            = 32'h921e_e5d5;
    arst_n          = 1'b0;
    cfg_we          = 1'b0;
    cfg_idx         = '0;
    cfg_wdata       = '0;
    trace           = '0;
    rd_pop          = 1'b0;
    ev              = '0;
    ev_rptr         = '0;
    exp_head        = '0;
    count_chk       = 1'b0;
    exp_count       = 0;
    rec_acc         = 1'b0;
    wm_shadow       = 0;
    sel_shadow      = 0;
    trace_en_shadow = 1'b0;
    trig_en_shadow  = 1'b0;
    trig_shadow     = '0;
    exp_trig        = 1'b0;
    exp_wptr        = '0;
    ev_chk          = '0;
    for (int c = 0; c < NumCores; c++) begin
      exp_ev[c]  = '0;
      ev_slot[c] = 0;
      ev_wr[c]   = 0;
      ev_rd[c]   = 0;
    end
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // Format and core selection with capture on and off
    write_cfg(RegEnable, 32'h1);
    for (int s = 0; s < NumCores; s++) begin
      write_cfg(RegCoreSel, s);
      repeat (3) begin
        drive_traces(8, 1'b0, 1'b0);
        drain_records();
      end
      write_cfg(RegEnable, 32'h0);
      drive_traces(6, 1'b0, 1'b1);
      drain_records();
      write_cfg(RegEnable, 32'h1);
    end

    // Trigger armed, disarmed, and on an unused core index
    write_cfg(RegTrigAddr, $random(seed) & 32'hffff_fffe);
    write_cfg(RegEnable, 32'h3);
    repeat (2) begin
      drive_traces(8, 1'b1, 1'b0);
      drain_records();
    end
    write_cfg(RegEnable, 32'h1);
    drive_traces(8, 1'b1, 1'b0);
    drain_records();
    write_cfg(RegEnable, 32'h3);
    write_cfg(RegCoreSel, 0);
    drive_traces(8, 1'b1, 1'b0);
    drain_records();
    write_cfg(RegCoreSel, 5);
    drive_traces(6, 1'b1, 1'b1);
    drain_records();

    // Watermark at five and overflow past the depth
    write_cfg(RegCoreSel, 1);
    write_cfg(RegWatermark, 5);
    drive_traces(12, 1'b0, 1'b1);
    drain_records();

    // Event export with reader stalls
    event_round(3);
    event_round(10);
    event_round(7);
    event_round(12);

    if (dut0.i_asserts.fail_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "assertion checks reported errors");
    end
  end

  initial begin
    wait (dut0.i_asserts.fail_count != 0);
    $display("Test failed");
    $fatal(1, "an assertion check reported an error");
  end

  initial begin
    #(WatchdogNs);
    $display("Test failed");
    $fatal(1, "timeout, the test sequence did not finish in time");
  end

endmodule

`default_nettype wire

/* testbench/snoop_top_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module snoop_top_asserts #(
  parameter int unsigned NumCores      = snoop_pkg::NumCoresDef,
  parameter int unsigned TraceLogDepth = snoop_pkg::TraceLogDepthDef,
  parameter int unsigned EventLogDepth = snoop_pkg::EventLogDepthDef
) (
  input logic                                 clk_i,
  input logic                                 arst_n_i,
  input logic                                 rd_pop_i,
  input snoop_pkg::trace_rec_t                rd_rec_o,
  input logic [TraceLogDepth:0]               rd_count_o,
  input logic                                 watermark_irq_o,
  input logic                                 trigger_irq_o,
  input logic [NumCores-1:0][EventLogDepth:0] ev_wptr_o,
  input snoop_pkg::pmu_event_t [NumCores-1:0][(2**EventLogDepth)-1:0] ev_data_o
);

  import snoop_pkg::*;

  int unsigned fail_count = 0;

  // ------------------------------------------------------------
  // Reset and trace path
  // ------------------------------------------------------------
  a_reset: assert property (@(posedge clk_i) !arst_n_i |-> !trigger_irq_o && !watermark_irq_o
                            && rd_count_o == '0 && ev_wptr_o == '0)
    else begin
      fail_count++;
      $error("error in reset, trigger_irq_o %h watermark_irq_o %h rd_count_o %h ev_wptr_o %h",
             $sampled(trigger_irq_o), $sampled(watermark_irq_o), $sampled(rd_count_o),
             $sampled(ev_wptr_o));
    end

  a_record: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                             rd_pop_i |-> rd_rec_o == tb_snoop_top.exp_head)
    else begin
      fail_count++;
      $error("error rd_rec_o got %h exp %h", $sampled(rd_rec_o),
             $sampled(tb_snoop_top.exp_head));
    end

  a_count: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                            tb_snoop_top.count_chk |-> rd_count_o == tb_snoop_top.exp_count)
    else begin
      fail_count++;
      $error("error rd_count_o got %h exp %h", $sampled(rd_count_o),
             $sampled(tb_snoop_top.exp_count));
    end

  // Level follows the expected fill whenever a watermark is set
  a_watermark: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                watermark_irq_o == (tb_snoop_top.wm_shadow != 0
                                && tb_snoop_top.exp_fill >= tb_snoop_top.wm_shadow))
    else begin
      fail_count++;
      $error("error watermark_irq_o got %h with fill %h watermark %h",
             $sampled(watermark_irq_o), $sampled(tb_snoop_top.exp_fill),
             $sampled(tb_snoop_top.wm_shadow));
    end

  a_trigger: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                              trigger_irq_o == $past(tb_snoop_top.exp_trig))
    else begin
      fail_count++;
      $error("error trigger_irq_o got %h exp %h", $sampled(trigger_irq_o),
             $past(tb_snoop_top.exp_trig));
    end

  // ------------------------------------------------------------
  // Event FIFOs per core
  // ------------------------------------------------------------
  for (genvar c = 0; c < NumCores; c++) begin : gen_ev_chk
    a_ev_wptr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                ev_wptr_o[c] == $past(tb_snoop_top.exp_wptr[c]))
      else begin
        fail_count++;
        $error("error ev_wptr_o[%0d] got %h exp %h", c, $sampled(ev_wptr_o[c]),
               $past(tb_snoop_top.exp_wptr[c]));
      end

    a_ev_slot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                tb_snoop_top.ev_chk[c] |->
                                ev_data_o[c][tb_snoop_top.ev_slot[c]] == tb_snoop_top.exp_ev[c])
      else begin
        fail_count++;
        $error("error ev_data_o[%0d][%0d] got %h exp %h", c,
               $sampled(tb_snoop_top.ev_slot[c]),
               $sampled(ev_data_o[c][tb_snoop_top.ev_slot[c]]),
               $sampled(tb_snoop_top.exp_ev[c]));
      end
  end

endmodule

`default_nettype wire

/* design/snoop_top.sv */
`timescale 1ns/1ps
`default_nettype none

module snoop_top #(
  parameter int unsigned NumCores      = snoop_pkg::NumCoresDef,
  parameter int unsigned TraceLogDepth = snoop_pkg::TraceLogDepthDef,
  parameter int unsigned EventLogDepth = snoop_pkg::EventLogDepthDef,
  parameter int unsigned SyncStages    = snoop_pkg::SyncStagesDef
) (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  // Configuration write strobe
  input  logic                                     cfg_we_i,
  input  snoop_pkg::reg_idx_t                      cfg_idx_i,
  input  snoop_pkg::word_t                         cfg_wdata_i,
  // Branch trace and record readout
  input  snoop_pkg::branch_trace_t [NumCores-1:0]  trace_i,
  input  logic                                     rd_pop_i,
  output snoop_pkg::trace_rec_t                    rd_rec_o,
  output logic [TraceLogDepth:0]                   rd_count_o,
  output logic                                     watermark_irq_o,
  output logic                                     trigger_irq_o,
  // Performance events, source half of the CDC
  input  snoop_pkg::pmu_event_t [NumCores-1:0]     ev_i,
  output logic [NumCores-1:0][EventLogDepth:0]     ev_wptr_o,
  output snoop_pkg::pmu_event_t [NumCores-1:0][(2**EventLogDepth)-1:0] ev_data_o,
  input  logic [NumCores-1:0][EventLogDepth:0]     ev_rptr_i
);

  import snoop_pkg::*;

  snoop_cfg_t cfg;
  trace_rec_t rec;
  logic       rec_valid;

  snoop_cfg_regs i_cfg_regs (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_idx_i   ( cfg_idx_i   ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_o       ( cfg         )
  );

  // ------------------------------------------------------------
  // Trace path
  // ------------------------------------------------------------
  trace_capture #(
    .NumCores ( NumCores )
  ) i_trace_capture (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .cfg_i         ( cfg           ),
    .trace_i       ( trace_i       ),
    .rec_o         ( rec           ),
    .rec_valid_o   ( rec_valid     ),
    .trigger_irq_o ( trigger_irq_o )
  );

  trace_buffer #(
    .LogDepth ( TraceLogDepth )
  ) i_trace_buffer (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .cfg_i           ( cfg             ),
    .rec_i           ( rec             ),
    .rec_valid_i     ( rec_valid       ),
    .rd_pop_i        ( rd_pop_i        ),
    .rd_rec_o        ( rd_rec_o        ),
    .rd_count_o      ( rd_count_o      ),
    .watermark_irq_o ( watermark_irq_o )
  );

  // One event FIFO per core
  for (genvar c = 0; c < NumCores; c++) begin : gen_event
    event_cdc_src #(
      .LogDepth   ( EventLogDepth ),
      .SyncStages ( SyncStages    )
    ) i_event_cdc_src (
      .clk_i     ( clk_i        ),
      .arst_n_i  ( arst_n_i     ),
      .ev_i      ( ev_i[c]      ),
      .ev_wptr_o ( ev_wptr_o[c] ),
      .ev_data_o ( ev_data_o[c] ),
      .ev_rptr_i ( ev_rptr_i[c] )
    );
  end

endmodule

`default_nettype wire

/* design/event_cdc_src.sv */
`timescale 1ns/1ps
`default_nettype none

module event_cdc_src #(
  parameter int unsigned LogDepth   = snoop_pkg::EventLogDepthDef,
  parameter int unsigned SyncStages = snoop_pkg::SyncStagesDef
) (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  snoop_pkg::pmu_event_t                       ev_i,
  output logic [LogDepth:0]                           ev_wptr_o,
  output snoop_pkg::pmu_event_t [(2**LogDepth)-1:0]   ev_data_o,
  input  logic [LogDepth:0]                           ev_rptr_i
);

  import snoop_pkg::*;

  localparam int unsigned Depth = 2 ** LogDepth;
  // Gray pointers of a full FIFO differ in their top two bits
  localparam logic [LogDepth:0] FullMask = 2'b11 << (LogDepth - 1);

  pmu_event_t [Depth-1:0] slots_q;

  logic [LogDepth:0]                  wptr_bin_q;
  logic [LogDepth:0]                  wptr_gray_q;
  logic [LogDepth:0]                  wptr_bin_next;
  logic [SyncStages-1:0][LogDepth:0]  rptr_sync_q;
  logic [LogDepth:0]                  rptr_gray;
  logic                               full;
  logic                               wr_en;

  // ------------------------------------------------------------
  // Read pointer synchronizer
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rptr_sync_q <= '0;
    end else begin
      rptr_sync_q[0] <= ev_rptr_i;
      for (int i = 1; i < SyncStages; i++) begin
        rptr_sync_q[i] <= rptr_sync_q[i-1];
      end
    end
  end

  assign rptr_gray = rptr_sync_q[SyncStages-1];
  assign full      = (wptr_gray_q == (rptr_gray ^ FullMask));

  // Events with id zero carry nothing
  assign wr_en         = (ev_i.e_id != '0) & ~full;
  assign wptr_bin_next = wptr_bin_q + 1'b1;

  // ------------------------------------------------------------
  // Write side
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_bin_q  <= '0;
      wptr_gray_q <= '0;
    end else if (wr_en) begin
      wptr_bin_q  <= wptr_bin_next;
      wptr_gray_q <= wptr_bin_next ^ (wptr_bin_next >> 1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      slots_q[wptr_bin_q[LogDepth-1:0]] <= ev_i;
    end
  end

  assign ev_wptr_o = wptr_gray_q;
  assign ev_data_o = slots_q;

endmodule

`default_nettype wire

/* design/trace_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_buffer #(
  parameter int unsigned LogDepth = snoop_pkg::TraceLogDepthDef
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  snoop_pkg::snoop_cfg_t cfg_i,
  input  snoop_pkg::trace_rec_t rec_i,
  input  logic                  rec_valid_i,
  input  logic                  rd_pop_i,
  output snoop_pkg::trace_rec_t rd_rec_o,
  output logic [LogDepth:0]     rd_count_o,
  output logic                  watermark_irq_o
);

  import snoop_pkg::*;

  localparam int unsigned Depth = 2 ** LogDepth;

  trace_rec_t [Depth-1:0] mem_q;

  logic [LogDepth-1:0] wr_ptr_q;
  logic [LogDepth-1:0] rd_ptr_q;
  logic [LogDepth:0]   count_q;
  logic                full;
  logic                empty;
  logic                push;
  logic                pop;
  count_t              count_ext;

  assign full  = (count_q == Depth[LogDepth:0]);
  assign empty = (count_q == '0);

  // A pop in the same cycle frees the slot for a push into a full buffer
  assign push = rec_valid_i & (~full | rd_pop_i);
  assign pop  = rd_pop_i & ~empty;

  // ------------------------------------------------------------
  // Pointers and fill count
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Record storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= rec_i;
    end
  end

  // Head is visible without a read latency
  assign rd_rec_o   = mem_q[rd_ptr_q];
  assign rd_count_o = count_q;

  // ------------------------------------------------------------
  // Watermark level
  // ------------------------------------------------------------
  assign count_ext       = count_t'(count_q);
  assign watermark_irq_o = (cfg_i.watermark != '0) && (count_ext >= cfg_i.watermark);

endmodule

`default_nettype wire

/* design/trace_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_capture #(
  parameter int unsigned NumCores = snoop_pkg::NumCoresDef
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  snoop_pkg::snoop_cfg_t                  cfg_i,
  input  snoop_pkg::branch_trace_t [NumCores-1:0] trace_i,
  output snoop_pkg::trace_rec_t                  rec_o,
  output logic                                   rec_valid_o,
  output logic                                   trigger_irq_o
);

  import snoop_pkg::*;

  branch_trace_t sel_trace;
  trace_rec_t    rec_d;
  logic          sel_ok;
  logic          rec_fire;
  logic          trig_hit;

  // Out-of-range core indices read as idle
  assign sel_ok    = (cfg_i.core_sel < NumCores);
  assign sel_trace = sel_ok ? trace_i[cfg_i.core_sel] : '0;

  // ------------------------------------------------------------
  // Record formatting
  // ------------------------------------------------------------
  assign rec_d.priv     = sel_trace.priv;
  assign rec_d.pc_src_h = {1'b0, sel_trace.src_pc[62:32]};
  assign rec_d.pc_src_l = {sel_trace.src_pc[31:1], 1'b0};
  assign rec_d.pc_dst_h = {1'b0, sel_trace.dst_pc[62:32]};
  assign rec_d.pc_dst_l = {sel_trace.dst_pc[31:1], 1'b0};
  assign rec_d.metadata = {{(WordWidth-CtrTypeWidth){1'b0}}, sel_trace.ctr_type};
  assign rec_d.opcode   = sel_trace.instr;

  assign rec_fire = sel_trace.valid & cfg_i.trace_en;
  assign trig_hit = rec_fire & cfg_i.trig_en & (rec_d.pc_src_l == cfg_i.trig_addr);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rec_valid_o   <= 1'b0;
      trigger_irq_o <= 1'b0;
    end else begin
      rec_valid_o   <= rec_fire;
      trigger_irq_o <= trig_hit;
    end
  end

  // Payload only loads with a new record
  always_ff @(posedge clk_i) begin
    if (rec_fire) begin
      rec_o <= rec_d;
    end
  end

endmodule

`default_nettype wire

/* design/snoop_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module snoop_cfg_regs (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 cfg_we_i,
  input  snoop_pkg::reg_idx_t  cfg_idx_i,
  input  snoop_pkg::word_t     cfg_wdata_i,
  output snoop_pkg::snoop_cfg_t cfg_o
);

  import snoop_pkg::*;

  snoop_cfg_t cfg_q;

  // ------------------------------------------------------------
  // Register write decode
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q <= '0;
    end else if (cfg_we_i) begin
      case (cfg_idx_i)
        RegCoreSel: begin
          cfg_q.core_sel <= cfg_wdata_i[CoreIdxWidth-1:0];
        end
        RegWatermark: begin
          cfg_q.watermark <= cfg_wdata_i[CountWidth-1:0];
        end
        RegTrigAddr: begin
          cfg_q.trig_addr <= cfg_wdata_i;
        end
        RegEnable: begin
          // Bit 0 enables capture, bit 1 arms the trigger
          cfg_q.trace_en <= cfg_wdata_i[0];
          cfg_q.trig_en  <= cfg_wdata_i[1];
        end
        default: begin
          cfg_q <= cfg_q;
        end
      endcase
    end
  end

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

/* design/snoop_pkg.sv */
`default_nettype none

package snoop_pkg;

  // ------------------------------------------------------------
  // Default top-level parameters
  // ------------------------------------------------------------
  localparam int unsigned NumCoresDef      = 2;
  localparam int unsigned TraceLogDepthDef = 3;
  localparam int unsigned EventLogDepthDef = 2;
  localparam int unsigned SyncStagesDef    = 3;

  // ------------------------------------------------------------
  // Widths and vector types
  // ------------------------------------------------------------
  localparam int unsigned WordWidth    = 32;
  localparam int unsigned PcWidth      = 64;
  localparam int unsigned CtrTypeWidth = 4;
  localparam int unsigned CoreIdxWidth = 4;
  localparam int unsigned CountWidth   = 8;

  typedef logic [WordWidth-1:0]    word_t;
  typedef logic [PcWidth-1:0]      pc_t;
  typedef logic [1:0]              priv_t;
  typedef logic [CtrTypeWidth-1:0] ctr_type_t;
  typedef logic [1:0]              reg_idx_t;
  typedef logic [CoreIdxWidth-1:0] core_idx_t;
  typedef logic [CountWidth-1:0]   count_t;

  // Configuration register map
  localparam reg_idx_t RegCoreSel   = 2'd0;
  localparam reg_idx_t RegWatermark = 2'd1;
  localparam reg_idx_t RegTrigAddr  = 2'd2;
  localparam reg_idx_t RegEnable    = 2'd3;

  // ------------------------------------------------------------
  // Bundles
  // ------------------------------------------------------------
  // Raw branch trace of one core
  typedef struct packed {
    logic      valid;
    pc_t       src_pc;
    pc_t       dst_pc;
    ctr_type_t ctr_type;
    priv_t     priv;
    word_t     instr;
  } branch_trace_t;

  // Snooper record layout
  typedef struct packed {
    priv_t priv;
    word_t pc_src_h;
    word_t pc_src_l;
    word_t pc_dst_h;
    word_t pc_dst_l;
    word_t metadata;
    word_t opcode;
  } trace_rec_t;

  typedef struct packed {
    logic [7:0]  e_id;
    logic [15:0] e_info;
    logic [7:0]  s_id;
  } pmu_event_t;

  typedef struct packed {
    core_idx_t core_sel;
    count_t    watermark;
    word_t     trig_addr;
    logic      trace_en;
    logic      trig_en;
  } snoop_cfg_t;

endpackage

`default_nettype wire
